// ==== compile.f ====
+incdir+source
source/user_pkg.sv
source/obi_bus_if.sv
source/user_addr_decode.sv
source/user_rom.sv
source/user_err_sbr.sv
source/user_rsp_mux.sv
source/user_domain.sv
dv/tb_clk_gen.sv
dv/tb_user_domain.sv

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HALF_PERIOD  = 5,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free running clock, 10 ns period
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset held low over the first rising edges, released just after one
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// ==== dv/tb_user_domain.sv ====
// Testbench for the user domain with random OBI traffic, a reference model and a timeout
`timescale 1ns/1ps

`include "user_domain_config.svh"

module tb_user_domain;

  // ----------------------------------------------------------
  // Run length and model constants
  // ----------------------------------------------------------

  localparam int unsigned NUM_CYCLES     = 2000;
  localparam int unsigned RESET_CYCLES   = 4;
  localparam int unsigned TIMEOUT_CYCLES = NUM_CYCLES + RESET_CYCLES + 100;
  localparam logic [31:0] SEED           = 32'd69;

  // Expected ROM contents
  // Word k is first plus k increments
  localparam logic [`USER_DATA_W-1:0] ROM_FIRST = 32'hC0DE_0000;
  localparam logic [`USER_DATA_W-1:0] ROM_INCR  = 32'h0000_1111;
  // Bytes covered by the ROM from the window base
  localparam logic [`USER_ADDR_W-1:0] ROM_SPAN  = `USER_ROM_WORDS * 4;

  logic                      clk;
  logic                      rst_n;

  // DUT request side
  logic                      req;
  logic                      we;
  logic [`USER_ADDR_W-1:0]   addr;
  logic [`USER_DATA_W/8-1:0] be;
  logic [`USER_DATA_W-1:0]   wdata;
  logic [`USER_ID_W-1:0]     aid;

  // DUT response side
  logic                      gnt;
  logic                      rvalid;
  logic                      err;
  logic [`USER_DATA_W-1:0]   rdata;
  logic [`USER_ID_W-1:0]     rid;

  // One-deep slot with the response due next cycle
  logic                      exp_valid;
  logic                      exp_err;
  logic [`USER_DATA_W-1:0]   exp_data;
  logic [`USER_ID_W-1:0]     exp_rid;

  logic [`USER_ID_W-1:0]     aid_cnt;
  logic [31:0]               rng_state;
  int unsigned               cycle_cnt;

  tb_clk_gen #(
    .HALF_PERIOD  ( 5            ),
    .RESET_CYCLES ( RESET_CYCLES )
  ) i_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  user_domain i_dut (
    .clk_i    ( clk    ),
    .rst_n_i  ( rst_n  ),
    .req_i    ( req    ),
    .we_i     ( we     ),
    .addr_i   ( addr   ),
    .be_i     ( be     ),
    .wdata_i  ( wdata  ),
    .aid_i    ( aid    ),
    .gnt_o    ( gnt    ),
    .rvalid_o ( rvalid ),
    .err_o    ( err    ),
    .rdata_o  ( rdata  ),
    .rid_o    ( rid    )
  );

  // ----------------------------------------------------------
  // Random numbers and reference model
  // ----------------------------------------------------------

  // Linear congruential generator
  // Upper bits are the useful ones
  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Address lands inside the ROM table
  function automatic logic rom_hit(input logic [`USER_ADDR_W-1:0] a);
    return (a >= `USER_BASE) && (a < `USER_BASE + ROM_SPAN);
  endfunction

  function automatic logic [`USER_DATA_W-1:0] rom_word(input logic [`USER_ADDR_W-1:0] a);
    logic [`USER_ADDR_W-1:0] k;
    k = (a - `USER_BASE) >> 2;
    return ROM_FIRST + ROM_INCR * k;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "bit compare failed");
    end
  endtask

  task automatic check_word(input string name, input logic [`USER_DATA_W-1:0] actual,
                            input logic [`USER_DATA_W-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "word compare failed");
    end
  endtask

  task automatic check_id(input string name, input logic [`USER_ID_W-1:0] actual,
                          input logic [`USER_ID_W-1:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1, "id compare failed");
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus and per-cycle check
  // ----------------------------------------------------------

  task automatic drive_idle();
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    be    = '0;
    wdata = '0;
    aid   = aid_cnt;
  endtask

  // Request in about 3 of 4 cycles
  // Addresses mostly inside the ROM
  task automatic drive_random();
    logic [31:0] r_ctl;
    logic [31:0] r_addr;
    r_ctl  = next_rand();
    r_addr = next_rand();
    req    = (r_ctl[31:30] != 2'b00);
    we     = r_ctl[29];
    be     = r_ctl[23:20];
    wdata  = next_rand();
    aid    = aid_cnt;
    if (r_ctl[27:24] < 4'd12) begin
      // Word index and byte offset
      addr = `USER_BASE + {26'h0, r_addr[31:28], r_addr[27:26]};
    end else if (r_ctl[27:24] < 4'd14) begin
      // Window but past the table
      addr = `USER_BASE + ROM_SPAN + {16'h0, r_addr[31:16]};
    end else begin
      addr = r_addr;
    end
  endtask

  // Checks the response due now, then loads the slot with this cycle's request
  task automatic check_cycle();
    check_bit("gnt_o", gnt, req);
    check_bit("rvalid_o", rvalid, exp_valid);
    if (exp_valid) begin
      check_bit("err_o", err, exp_err);
      check_word("rdata_o", rdata, exp_data);
      check_id("rid_o", rid, exp_rid);
    end
    exp_valid = req;
    if (req) begin
      exp_rid = aid;
      if (rom_hit(addr)) begin
        exp_err  = 1'b0;
        exp_data = we ? '0 : rom_word(addr);
      end else begin
        exp_err  = 1'b1;
        exp_data = `USER_ERR_DATA;
      end
      aid_cnt = aid_cnt + `USER_ID_W'(1);
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    rng_state = SEED;
    aid_cnt   = '0;
    exp_valid = 1'b0;
    exp_err   = 1'b0;
    exp_data  = '0;
    exp_rid   = '0;
    drive_idle();

    // Quiet during reset and in the first cycle after it
    do begin
      @(negedge clk);
      check_bit("gnt_o", gnt, req);
      check_bit("rvalid_o", rvalid, 1'b0);
    end while (!rst_n);

    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      #1;
      drive_random();
      @(negedge clk);
      check_cycle();
    end

    // Drain the last response
    @(posedge clk);
    #1;
    drive_idle();
    @(negedge clk);
    check_cycle();

    $display("TB PASSED");
    $finish;
  end

  // Ends a run that stalls
  initial begin
    cycle_cnt = 0;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the user domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_user_domain \
  -f compile.f \
  --Mdir obj_dir \
  -o sim_tb_user_domain
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_user_domain
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// ==== source/obi_bus_if.sv ====
// Interface for one internal OBI request and response channel
`timescale 1ns/1ps

`include "user_domain_config.svh"

interface obi_bus_if;

  // ----------------------------------------------------------
  // Request channel, manager side drives
  // ----------------------------------------------------------
  logic                       req;
  logic [`USER_ADDR_W-1:0]    addr;
  logic                       we;
  logic [`USER_DATA_W/8-1:0]  be;
  logic [`USER_DATA_W-1:0]    wdata;
  logic [`USER_ID_W-1:0]      aid;

  // ----------------------------------------------------------
  // Response channel, subordinate side drives
  // ----------------------------------------------------------
  logic                       gnt;
  logic                       rvalid;
  logic [`USER_DATA_W-1:0]    rdata;
  logic                       err;
  logic [`USER_ID_W-1:0]      rid;

  // Decoder end
  modport mgr (
    output req, addr, we, be, wdata, aid,
    input  gnt, rvalid, rdata, err, rid
  );

  // Subordinate end
  modport sbr (
    input  req, addr, we, be, wdata, aid,
    output gnt, rvalid, rdata, err, rid
  );

  // Response monitor for the result stage
  modport rsp (
    input rvalid, rdata, err, rid
  );

endinterface

// ==== source/user_addr_decode.sv ====
// Decode stage mapping the address to a subordinate and routing req and gnt
`timescale 1ns/1ps

`include "user_domain_config.svh"

module user_addr_decode import user_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`USER_ADDR_W-1:0]   addr_i,
  input  logic [`USER_DATA_W/8-1:0] be_i,
  input  logic [`USER_DATA_W-1:0]   wdata_i,
  input  logic [`USER_ID_W-1:0]     aid_i,
  output logic                      gnt_o,
  output user_sel_e                 sel_o,
  obi_bus_if.mgr                    rom_bus,
  obi_bus_if.mgr                    err_bus
);

  // Region field of the window base
  localparam logic [USER_REGION_W-1:0] ROM_REGION =
    USER_REGION_W'(`USER_BASE >> (USER_IDX_W + USER_OFFS_W));

  user_addr_u addr_u;
  logic       rom_hit;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------

  assign addr_u.flat = addr_i;

  // Region match and index inside the table
  assign rom_hit = (addr_u.rom.region == ROM_REGION) &&
                   (int'(addr_u.rom.idx) < `USER_ROM_WORDS);

  // Anything that misses the ROM goes to the error subordinate
  always_comb begin
    sel_o = SEL_ERR;
    if (rom_hit) begin
      sel_o = SEL_ROM;
    end
  end

  // ----------------------------------------------------------
  // Request routing
  // ----------------------------------------------------------

  // Payload fans out to both subordinates
  // Only req is steered
  assign rom_bus.addr  = addr_i;
  assign rom_bus.we    = we_i;
  assign rom_bus.be    = be_i;
  assign rom_bus.wdata = wdata_i;
  assign rom_bus.aid   = aid_i;
  assign rom_bus.req   = req_i && (sel_o == SEL_ROM);

  assign err_bus.addr  = addr_i;
  assign err_bus.we    = we_i;
  assign err_bus.be    = be_i;
  assign err_bus.wdata = wdata_i;
  assign err_bus.aid   = aid_i;
  assign err_bus.req   = req_i && (sel_o == SEL_ERR);

  // Grant comes from the selected subordinate
  assign gnt_o = (sel_o == SEL_ROM) ? rom_bus.gnt : err_bus.gnt;

  // Both subordinates are always ready
  a_gnt_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    gnt_o == req_i
  );

endmodule

// ==== source/user_domain.sv ====
// Top level of the user peripheral domain with plain OBI subordinate ports
`timescale 1ns/1ps

`include "user_domain_config.svh"

module user_domain import user_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // OBI request from the crossbar
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [`USER_ADDR_W-1:0]   addr_i,
  input  logic [`USER_DATA_W/8-1:0] be_i,
  input  logic [`USER_DATA_W-1:0]   wdata_i,
  input  logic [`USER_ID_W-1:0]     aid_i,

  // OBI response back to the crossbar
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic                      err_o,
  output logic [`USER_DATA_W-1:0]   rdata_o,
  output logic [`USER_ID_W-1:0]     rid_o
);

  // Subordinate chosen by the decoder
  user_sel_e sel;

  // Internal subordinate channels
  obi_bus_if i_rom_bus ();
  obi_bus_if i_err_bus ();

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------

  user_addr_decode i_decode (
    .clk_i   ( clk_i           ),
    .rst_n_i ( rst_n_i         ),
    .req_i   ( req_i           ),
    .we_i    ( we_i            ),
    .addr_i  ( addr_i          ),
    .be_i    ( be_i            ),
    .wdata_i ( wdata_i         ),
    .aid_i   ( aid_i           ),
    .gnt_o   ( gnt_o           ),
    .sel_o   ( sel             ),
    .rom_bus ( i_rom_bus.mgr   ),
    .err_bus ( i_err_bus.mgr   )
  );

  // ----------------------------------------------------------
  // Execute
  // ----------------------------------------------------------

  // Table subordinate
  user_rom i_rom (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .bus     ( i_rom_bus.sbr )
  );

  // Default target for unmapped addresses
  user_err_sbr i_err_sbr (
    .clk_i   ( clk_i         ),
    .rst_n_i ( rst_n_i       ),
    .bus     ( i_err_bus.sbr )
  );

  // ----------------------------------------------------------
  // Result
  // ----------------------------------------------------------

  user_rsp_mux i_rsp_mux (
    .clk_i    ( clk_i         ),
    .rst_n_i  ( rst_n_i       ),
    .gnt_i    ( gnt_o         ),
    .sel_i    ( sel           ),
    .rom_bus  ( i_rom_bus.rsp ),
    .err_bus  ( i_err_bus.rsp ),
    .rvalid_o ( rvalid_o      ),
    .err_o    ( err_o         ),
    .rdata_o  ( rdata_o       ),
    .rid_o    ( rid_o         )
  );

endmodule

// ==== source/user_domain_config.svh ====
// Bus widths, user window base, ROM depth and error response word
`ifndef USER_DOMAIN_CONFIG_SVH
`define USER_DOMAIN_CONFIG_SVH

// ----------------------------------------------------------
// OBI channel widths
// ----------------------------------------------------------

// Address and data words
`define USER_ADDR_W 32
`define USER_DATA_W 32

// Transaction id, echoed back as rid
`define USER_ID_W 2

// ----------------------------------------------------------
// Address map and subordinate contents
// ----------------------------------------------------------

// Start of the user window, only the upper bits are decoded
`define USER_BASE 32'h2000_0000

// ROM depth in words
`define USER_ROM_WORDS 16

// Read data returned by the error subordinate
`define USER_ERR_DATA 32'hBADC_AB1E

`endif

// ==== source/user_err_sbr.sv ====
// Execute stage error subordinate answering every access with err set
`timescale 1ns/1ps

`include "user_domain_config.svh"

module user_err_sbr import user_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus
);

  // Region field of the window base
  localparam logic [USER_REGION_W-1:0] ROM_REGION =
    USER_REGION_W'(`USER_BASE >> (USER_IDX_W + USER_OFFS_W));

  user_addr_u            addr_u;
  logic                  xfer;
  logic                  rvalid_q;
  logic [`USER_ID_W-1:0] rid_q;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  // Accepts everything at once
  assign bus.gnt = bus.req;
  assign xfer    = bus.req && bus.gnt;

  // ROM view of the incoming address
  assign addr_u.flat = bus.addr;

  // ----------------------------------------------------------
  // Response register
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  // Id echo
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rid_q <= bus.aid;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rid    = rid_q;

  // Same answer for reads and writes
  assign bus.err    = 1'b1;
  assign bus.rdata  = `USER_ERR_DATA;

  // Table addresses never land here
  a_req_outside_table : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus.req |-> !((addr_u.rom.region == ROM_REGION) &&
                  (int'(addr_u.rom.idx) < `USER_ROM_WORDS))
  );

endmodule

// ==== source/user_pkg.sv ====
// Package with subordinate select enum and packed address union
package user_pkg;

  `include "user_domain_config.svh"

  // Field widths of the ROM address view
  localparam int unsigned USER_OFFS_W   = $clog2(`USER_DATA_W / 8);
  localparam int unsigned USER_IDX_W    = $clog2(`USER_ROM_WORDS);
  localparam int unsigned USER_REGION_W = `USER_ADDR_W - USER_IDX_W - USER_OFFS_W;

  // Subordinate that owns a request
  typedef enum logic {
    SEL_ROM = 1'b0,
    SEL_ERR = 1'b1
  } user_sel_e;

  // ROM view of an address word
  typedef struct packed {
    // Upper bits, compared against the window base
    logic [USER_REGION_W-1:0] region;
    // Word inside the ROM
    logic [USER_IDX_W-1:0]    idx;
    // Byte lane, ignored
    logic [USER_OFFS_W-1:0]   offset;
  } user_rom_addr_t;

  // One address word, decoded two ways
  typedef union packed {
    // Raw bus address
    logic [`USER_ADDR_W-1:0] flat;
    // Region, index and byte offset
    user_rom_addr_t          rom;
  } user_addr_u;

endpackage

// ==== source/user_rom.sv ====
// Execute stage ROM subordinate with a registered one-cycle response
`timescale 1ns/1ps

`include "user_domain_config.svh"

module user_rom import user_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr bus
);

  // Word k is base plus k steps
  localparam logic [`USER_DATA_W-1:0] ROM_WORD0 = 32'hC0DE_0000;
  localparam logic [`USER_DATA_W-1:0] ROM_STEP  = 32'h0000_1111;

  // Region field of the window base
  localparam logic [USER_REGION_W-1:0] ROM_REGION =
    USER_REGION_W'(`USER_BASE >> (USER_IDX_W + USER_OFFS_W));

  logic [`USER_DATA_W-1:0] rom_table [`USER_ROM_WORDS];

  user_addr_u              addr_u;
  logic                    xfer;

  logic                    rvalid_q;
  logic [`USER_DATA_W-1:0] rdata_q;
  logic [`USER_ID_W-1:0]   rid_q;

  // ----------------------------------------------------------
  // Constant table
  // ----------------------------------------------------------

  for (genvar k = 0; k < `USER_ROM_WORDS; k++) begin : gen_table
    assign rom_table[k] = ROM_WORD0 + ROM_STEP * `USER_DATA_W'(k);
  end

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------

  // Always ready
  assign bus.gnt = bus.req;
  assign xfer    = bus.req && bus.gnt;

  // Word index from the ROM view
  assign addr_u.flat = bus.addr;

  // ----------------------------------------------------------
  // Response register
  // ----------------------------------------------------------

  // Valid flag
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= xfer;
    end
  end

  // Payload loaded on each transfer
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rid_q <= bus.aid;
      // Writes are acked with zero data and leave the table alone
      if (bus.we) begin
        rdata_q <= '0;
      end else begin
        rdata_q <= rom_table[addr_u.rom.idx];
      end
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.rid    = rid_q;
  // Never errors
  assign bus.err    = 1'b0;

  // Only table addresses are routed here
  a_req_in_table : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bus.req |-> (addr_u.rom.region == ROM_REGION) &&
                (int'(addr_u.rom.idx) < `USER_ROM_WORDS)
  );

endmodule

// ==== source/user_rsp_mux.sv ====
// Result stage returning the response of the subordinate chosen at grant
`timescale 1ns/1ps

`include "user_domain_config.svh"

module user_rsp_mux import user_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    gnt_i,
  input  user_sel_e               sel_i,
  obi_bus_if.rsp                  rom_bus,
  obi_bus_if.rsp                  err_bus,
  output logic                    rvalid_o,
  output logic                    err_o,
  output logic [`USER_DATA_W-1:0] rdata_o,
  output logic [`USER_ID_W-1:0]   rid_o
);

  // Response expected this cycle
  logic      pending_q;
  // Owner of that response
  user_sel_e sel_q;

  // ----------------------------------------------------------
  // Selection tracking
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= gnt_i;
    end
  end

  // Latched on grant, only read while pending
  always_ff @(posedge clk_i) begin
    if (gnt_i) begin
      sel_q <= sel_i;
    end
  end

  // ----------------------------------------------------------
  // Response select
  // ----------------------------------------------------------

  always_comb begin
    if (sel_q == SEL_ROM) begin
      rvalid_o = pending_q && rom_bus.rvalid;
      err_o    = rom_bus.err;
      rdata_o  = rom_bus.rdata;
      rid_o    = rom_bus.rid;
    end else begin
      rvalid_o = pending_q && err_bus.rvalid;
      err_o    = err_bus.err;
      rdata_o  = err_bus.rdata;
      rid_o    = err_bus.rid;
    end
  end

  // A subordinate only answers what was routed to it
  a_rom_rsp_owned : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rom_bus.rvalid |-> (pending_q && sel_q == SEL_ROM)
  );

  a_err_rsp_owned : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    err_bus.rvalid |-> (pending_q && sel_q == SEL_ERR)
  );

endmodule
